// File: common/cpuPkg.sv
package cpuPkg;

  // datapath, instruction and bus word width
  localparam int dataWidth = 16;
  // eight architectural registers
  localparam int regAddrWidth = 3;
  // default word count of the shared memory
  localparam int memDepth = 512;

  // top nibble of every instruction word
  typedef enum logic [3:0] {
    NOP = 4'd0,
    ADD = 4'd1,
    SUB = 4'd2,
    AND = 4'd3,
    LDM = 4'd4,
    LDD = 4'd5,
    STD = 4'd6,
    IN  = 4'd7,
    OUT = 4'd8,
    JZ  = 4'd9,
    HLT = 4'd15
  } opcodeT;

  // one instruction word, two decodings
  typedef union packed {
    // register form: ALU ops, IN, OUT
    struct packed {
      opcodeT                  opcode;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [2:0]              unused;
    } r;
    // immediate form: LDM, LDD, STD, JZ
    struct packed {
      opcodeT                  opcode;
      logic [regAddrWidth-1:0] rd;
      logic [8:0]              imm;
    } i;
  } instrU;

  // execute to memory stage register
  typedef struct packed {
    logic                    valid;
    opcodeT                  opcode;
    logic [regAddrWidth-1:0] rd;
    logic [dataWidth-1:0]    result;
    logic [dataWidth-1:0]    storeData;
    logic [dataWidth-1:0]    address;
  } exMemT;

endpackage

// File: common/wbBus.sv
`timescale 1ns/1ns

interface wbBus
  import cpuPkg::*;
();

  // cycle frame and strobe, held until ack
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [dataWidth-1:0] adr;
  logic [dataWidth-1:0] datWr;
  // slave side return
  logic [dataWidth-1:0] datRd;
  logic                 ack;

  modport master (
    output cyc, stb, we, adr, datWr,
    input  datRd, ack
  );

  modport slave (
    input  cyc, stb, we, adr, datWr,
    output datRd, ack
  );

endinterface

// File: fetch/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 pipeStall,
  input  logic                 branchTaken,
  input  logic [dataWidth-1:0] branchTarget,
  output instrU                instr,
  output logic                 instrValid,
  output logic [dataWidth-1:0] pcNext,
  wbBus.master                 fetchBus
);

  logic [dataWidth-1:0] pc;
  logic                 running;
  logic                 haltSeen;
  // open read overtaken by a taken branch
  logic                 dropRead;
  logic                 issue;
  logic                 readDone;
  instrU                fetched;

  assign fetched = fetchBus.datRd;
  assign readDone = fetchBus.cyc && fetchBus.ack;
  // one read at a time, only when IR is empty or handed on this cycle
  assign issue = running && !haltSeen && !fetchBus.cyc && !branchTaken
    && (!instrValid || !pipeStall);
  assign pcNext = pc;

  // read-only master
  assign fetchBus.stb = fetchBus.cyc;
  assign fetchBus.we = 1'b0;
  assign fetchBus.datWr = '0;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc <= '0;
      running <= 1'b0;
      haltSeen <= 1'b0;
      dropRead <= 1'b0;
      instrValid <= 1'b0;
      fetchBus.cyc <= 1'b0;
    end
    else
    begin
      if (start)
        running <= 1'b1;
      // execute takes the instruction
      if (instrValid && !pipeStall)
        instrValid <= 1'b0;
      if (issue)
      begin
        fetchBus.cyc <= 1'b1;
        pc <= pc + 1'b1;
      end
      if (readDone)
      begin
        fetchBus.cyc <= 1'b0;
        dropRead <= 1'b0;
        if (!dropRead && !branchTaken)
        begin
          instrValid <= 1'b1;
          // nothing past HLT gets fetched
          if (fetched.r.opcode == HLT)
            haltSeen <= 1'b1;
        end
      end
      // flush: drop held word, mark any open read stale
      if (branchTaken)
      begin
        pc <= branchTarget;
        instrValid <= 1'b0;
        haltSeen <= 1'b0;
        if (fetchBus.cyc && !fetchBus.ack)
          dropRead <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue)
      fetchBus.adr <= pc;
    if (readDone)
      instr <= fetched;
  end

  // read request stays put while arbiter or memory keep it waiting
  assert property (@(posedge clk) disable iff (rst)
    fetchBus.stb && !fetchBus.ack |=> fetchBus.stb && $stable(fetchBus.adr));

endmodule

// File: execute/executeStage.sv
`timescale 1ns/1ns

module executeStage
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  instrU                   instr,
  input  logic                    instrValid,
  input  logic                    pipeStall,
  input  logic [dataWidth-1:0]    rdDataA,
  input  logic [dataWidth-1:0]    rdDataB,
  input  logic                    fwdValid,
  input  logic [regAddrWidth-1:0] fwdReg,
  input  logic [dataWidth-1:0]    fwdData,
  input  logic [dataWidth-1:0]    inputPort,
  output logic [regAddrWidth-1:0] rdAddrA,
  output logic [regAddrWidth-1:0] rdAddrB,
  output logic                    branchTaken,
  output logic [dataWidth-1:0]    branchTarget,
  output exMemT                   exMem
);

  instrU                cur;
  opcodeT               op;
  logic [dataWidth-1:0] imm;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] result;
  logic                 takeBranch;

  // empty IR or branch shadow decodes as NOP
  assign cur = (instrValid && !branchTaken) ? instr : '0;
  assign op = cur.r.opcode;
  // 9-bit immediate, zero extended
  assign imm = {{(dataWidth - 9){1'b0}}, cur.i.imm};

  // JZ tests rd, STD stores rd, everything else reads rs/rt
  assign rdAddrA = (op == JZ || op == STD) ? cur.i.rd : cur.r.rs;
  assign rdAddrB = cur.r.rt;

  // bypass from the retiring instruction
  assign opA = (fwdValid && fwdReg == rdAddrA) ? fwdData : rdDataA;
  assign opB = (fwdValid && fwdReg == rdAddrB) ? fwdData : rdDataB;

  always_comb
  begin
    case (op)
      ADD:     result = opA + opB;
      SUB:     result = opA - opB;
      AND:     result = opA & opB;
      LDM:     result = imm;
      IN:      result = inputPort;
      // OUT passes rs through
      default: result = opA;
    endcase
  end

  // absolute target, taken on zero
  assign takeBranch = (op == JZ) && (opA == '0);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      branchTaken <= 1'b0;
      exMem <= '0;
    end
    else if (!pipeStall)
    begin
      branchTaken <= takeBranch;
      exMem.valid <= (op != NOP);
      exMem.opcode <= op;
      exMem.rd <= cur.i.rd;
      exMem.result <= result;
      exMem.storeData <= opA;
      // LDD/STD address straight from the immediate
      exMem.address <= imm;
    end
    else
    begin
      // single-cycle pulse even if the pipe froze
      branchTaken <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!pipeStall)
      branchTarget <= imm;
  end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ns

module regFile
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [regAddrWidth-1:0] rdAddrA,
  input  logic [regAddrWidth-1:0] rdAddrB,
  input  logic                    wrEn,
  input  logic [regAddrWidth-1:0] wrAddr,
  input  logic [dataWidth-1:0]    wrData,
  output logic [dataWidth-1:0]    rdDataA,
  output logic [dataWidth-1:0]    rdDataB
);

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  // write lands at the edge, same-cycle readers go through the bypass
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      regs <= '{default: '0};
    else if (wrEn)
      regs[wrAddr] <= wrData;
  end

  // asynchronous read ports
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

endmodule

// File: src/memStage.sv
`timescale 1ns/1ns

module memStage
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  exMemT                   exMem,
  output logic                    pipeStall,
  output logic                    wrEn,
  output logic [regAddrWidth-1:0] wrAddr,
  output logic [dataWidth-1:0]    wrData,
  output logic                    fwdValid,
  output logic [regAddrWidth-1:0] fwdReg,
  output logic [dataWidth-1:0]    fwdData,
  output logic [dataWidth-1:0]    outputPort,
  output logic                    outputValid,
  output logic                    halted,
  wbBus.master                    dataBus
);

  logic isLoad;
  logic memOp;
  logic retire;
  // idle cycle after each ack, so cyc drops between data cycles
  logic ackSeen;

  assign isLoad = (exMem.opcode == LDD);
  assign memOp = exMem.valid && (isLoad || exMem.opcode == STD);

  // bus fields come straight from the held stage register
  assign dataBus.cyc = memOp && !ackSeen;
  assign dataBus.stb = dataBus.cyc;
  assign dataBus.we = (exMem.opcode == STD);
  assign dataBus.adr = exMem.address;
  assign dataBus.datWr = exMem.storeData;

  // whole pipe frozen until the data cycle is acked
  assign pipeStall = memOp && !dataBus.ack;
  assign retire = exMem.valid && !pipeStall;

  always_comb
  begin
    case (exMem.opcode)
      ADD, SUB, AND, LDM, IN, LDD: wrEn = retire;
      default:                     wrEn = 1'b0;
    endcase
  end

  assign wrAddr = exMem.rd;
  // load data is taken in the ack cycle
  assign wrData = isLoad ? dataBus.datRd : exMem.result;

  // bypass mirrors the register write
  assign fwdValid = wrEn;
  assign fwdReg = wrAddr;
  assign fwdData = wrData;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ackSeen <= 1'b0;
      outputValid <= 1'b0;
      halted <= 1'b0;
    end
    else
    begin
      ackSeen <= dataBus.ack;
      outputValid <= retire && (exMem.opcode == OUT);
      // sticky once HLT retires
      if (retire && exMem.opcode == HLT)
        halted <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (retire && exMem.opcode == OUT)
      outputPort <= exMem.result;
  end

endmodule

// File: src/memArbiter.sv
`timescale 1ns/1ns

module memArbiter (
  input  logic clk,
  input  logic rst,
  wbBus.slave  hostBus,
  wbBus.slave  dataBus,
  wbBus.slave  fetchBus,
  wbBus.master memBus
);

  // bit 2 host, bit 1 memory stage, bit 0 fetch
  logic [2:0] req;
  logic [2:0] pick;
  logic [2:0] grant;
  logic [2:0] grantReg;
  logic       locked;

  assign req = {hostBus.cyc, dataBus.cyc, fetchBus.cyc};

  // fixed priority, host first
  always_comb
  begin
    pick = 3'b000;
    if (req[2])
      pick = 3'b100;
    else if (req[1])
      pick = 3'b010;
    else if (req[0])
      pick = 3'b001;
  end

  // owner keeps the bus while it holds cyc
  assign locked = |(grantReg & req);
  assign grant = locked ? grantReg : pick;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      grantReg <= 3'b000;
    else
      grantReg <= grant;
  end

  always_comb
  begin
    memBus.cyc = 1'b0;
    memBus.stb = 1'b0;
    memBus.we = 1'b0;
    memBus.adr = '0;
    memBus.datWr = '0;
    case (grant)
      3'b100:
      begin
        memBus.cyc = hostBus.cyc;
        memBus.stb = hostBus.stb;
        memBus.we = hostBus.we;
        memBus.adr = hostBus.adr;
        memBus.datWr = hostBus.datWr;
      end
      3'b010:
      begin
        memBus.cyc = dataBus.cyc;
        memBus.stb = dataBus.stb;
        memBus.we = dataBus.we;
        memBus.adr = dataBus.adr;
        memBus.datWr = dataBus.datWr;
      end
      3'b001:
      begin
        memBus.cyc = fetchBus.cyc;
        memBus.stb = fetchBus.stb;
        memBus.we = fetchBus.we;
        memBus.adr = fetchBus.adr;
        memBus.datWr = fetchBus.datWr;
      end
      default:
      begin
        memBus.cyc = 1'b0;
      end
    endcase
  end

  // ack belongs to whoever owned the bus last cycle too,
  // so a late ack from a one-cycle host strobe never leaks to a new owner
  assign hostBus.ack = grant[2] && grantReg[2] && memBus.ack;
  assign dataBus.ack = grant[1] && grantReg[1] && memBus.ack;
  assign fetchBus.ack = grant[0] && grantReg[0] && memBus.ack;
  assign hostBus.datRd = grant[2] ? memBus.datRd : '0;
  assign dataBus.datRd = grant[1] ? memBus.datRd : '0;
  assign fetchBus.datRd = grant[0] ? memBus.datRd : '0;

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

// File: src/unifiedMemory.sv
`timescale 1ns/1ns

module unifiedMemory
  import cpuPkg::*;
#(
  parameter int memDepth = cpuPkg::memDepth
)
(
  input  logic clk,
  input  logic rst,
  wbBus.slave  memBus
);

  localparam int addrBits = $clog2(memDepth);

  logic [dataWidth-1:0] mem [memDepth];
  logic [addrBits-1:0]  wordAddr;
  logic                 access;

  // upper address bits ignored
  assign wordAddr = memBus.adr[addrBits-1:0];
  assign access = memBus.cyc && memBus.stb;

  // a store held through its ack cycle rewrites the same word
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (memBus.we)
        mem[wordAddr] <= memBus.datWr;
      else
        memBus.datRd <= mem[wordAddr];
    end
  end

  // one ack per request, the cycle after the strobe
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      memBus.ack <= 1'b0;
    else
      memBus.ack <= access && !memBus.ack;
  end

  assert property (@(posedge clk) disable iff (rst)
    $rose(memBus.ack) |-> $past(memBus.stb));

endmodule

// File: src/processor.sv
`timescale 1ns/1ns

module processor
  import cpuPkg::*;
#(
  parameter int memDepth = cpuPkg::memDepth
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic [dataWidth-1:0] inputPort,
  input  logic                 loadWe,
  input  logic [dataWidth-1:0] loadAddr,
  input  logic [dataWidth-1:0] loadData,
  output logic [dataWidth-1:0] outputPort,
  output logic                 outputValid,
  output logic                 halted
);

  wbBus fetchBus ();
  wbBus dataBus ();
  wbBus hostBus ();
  wbBus memBus ();

  instrU                   instr;
  logic                    instrValid;
  logic [dataWidth-1:0]    pcNext;
  logic                    pipeStall;
  logic                    branchTaken;
  logic [dataWidth-1:0]    branchTarget;
  exMemT                   exMem;
  logic [regAddrWidth-1:0] rdAddrA;
  logic [regAddrWidth-1:0] rdAddrB;
  logic [dataWidth-1:0]    rdDataA;
  logic [dataWidth-1:0]    rdDataB;
  logic                    wrEn;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0]    wrData;
  logic                    fwdValid;
  logic [regAddrWidth-1:0] fwdReg;
  logic [dataWidth-1:0]    fwdData;

  // loader port as a write-only master, one word per strobe
  assign hostBus.cyc = loadWe;
  assign hostBus.stb = loadWe;
  assign hostBus.we = 1'b1;
  assign hostBus.adr = loadAddr;
  assign hostBus.datWr = loadData;

  fetchUnit u_fetchUnit (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .pipeStall    (pipeStall),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .instr        (instr),
    .instrValid   (instrValid),
    .pcNext       (pcNext),
    .fetchBus     (fetchBus.master)
  );

  executeStage u_executeStage (
    .clk          (clk),
    .rst          (rst),
    .instr        (instr),
    .instrValid   (instrValid),
    .pipeStall    (pipeStall),
    .rdDataA      (rdDataA),
    .rdDataB      (rdDataB),
    .fwdValid     (fwdValid),
    .fwdReg       (fwdReg),
    .fwdData      (fwdData),
    .inputPort    (inputPort),
    .rdAddrA      (rdAddrA),
    .rdAddrB      (rdAddrB),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .exMem        (exMem)
  );

  regFile u_regFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  memStage u_memStage (
    .clk         (clk),
    .rst         (rst),
    .exMem       (exMem),
    .pipeStall   (pipeStall),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .fwdValid    (fwdValid),
    .fwdReg      (fwdReg),
    .fwdData     (fwdData),
    .outputPort  (outputPort),
    .outputValid (outputValid),
    .halted      (halted),
    .dataBus     (dataBus.master)
  );

  memArbiter u_memArbiter (
    .clk      (clk),
    .rst      (rst),
    .hostBus  (hostBus.slave),
    .dataBus  (dataBus.slave),
    .fetchBus (fetchBus.slave),
    .memBus   (memBus.master)
  );

  unifiedMemory #(
    .memDepth (memDepth)
  ) u_unifiedMemory (
    .clk    (clk),
    .rst    (rst),
    .memBus (memBus.slave)
  );

  // once HLT has retired the fetch side stays parked
  assert property (@(posedge clk) disable iff (rst)
    halted |=> $stable(pcNext) && !fetchBus.cyc);

endmodule

// File: sim/processorTb.sv
`timescale 1ns/1ns

module processorTb
  import cpuPkg::*;
();

  localparam int clkPeriod = 100;
  // inputs change this long after the rising edge
  localparam int driveDelay = 5;
  localparam int vecDepth = 64;
  // header words ahead of the program in the vector file
  localparam int hdrWords = 3;
  localparam int idleWait = 5;
  localparam int postHalt = 4;

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic [dataWidth-1:0] inputPort;
  logic                 loadWe;
  logic [dataWidth-1:0] loadAddr;
  logic [dataWidth-1:0] loadData;
  logic [dataWidth-1:0] outputPort;
  logic                 outputValid;
  logic                 halted;

  // word 0 input port, word 1 program length, word 2 output count
  logic [dataWidth-1:0] vectors [vecDepth];
  int                   progLen;
  int                   expCount;
  int                   outCount;
  int                   errorCount;
  int                   checkCount;
  int                   cycleCount;
  logic                 started;
  logic                 vectorsOk;
  string                phase;

  processor #(
    .memDepth (memDepth)
  ) u_processor (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .inputPort   (inputPort),
    .loadWe      (loadWe),
    .loadAddr    (loadAddr),
    .loadData    (loadData),
    .outputPort  (outputPort),
    .outputValid (outputValid),
    .halted      (halted)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // compare one output strobe against the next expected word
  task automatic checkOutput();
    logic [dataWidth-1:0] expected;
    checkCount++;
    assert (outCount < expCount)
    else
    begin
      errorCount++;
      $display("extra output %0d appeared, only %0d expected", outCount, expCount);
    end
    if (outCount < expCount)
    begin
      expected = vectors[hdrWords + progLen + outCount];
      assert (outputPort === expected)
      else
      begin
        errorCount++;
        $display("Fail output %0d: expected %h, actual %h", outCount, expected, outputPort);
      end
    end
    outCount++;
  endtask

  // outputs sampled mid-cycle, away from the edges
  always @(negedge clk)
  begin
    if (!rst && !started)
    begin
      checkCount++;
      assert (!outputValid && !halted)
      else
      begin
        errorCount++;
        $display("output strobe or halted seen before start, %s phase", phase);
      end
    end
    else if (!rst && outputValid)
    begin
      checkOutput();
    end
  end

  // host writes one program word per cycle
  task automatic loadProgram();
    phase = "load";
    for (int i = 0; i < progLen; i++)
    begin
      @(posedge clk);
      #driveDelay;
      loadWe = 1'b1;
      loadAddr = i[dataWidth-1:0];
      loadData = vectors[hdrWords + i];
    end
    @(posedge clk);
    #driveDelay;
    loadWe = 1'b0;
    loadAddr = '0;
    loadData = '0;
  endtask

  // quiet stretch with start low, then release the core
  task automatic releaseCore();
    phase = "idle";
    repeat (idleWait) @(posedge clk);
    #driveDelay;
    start = 1'b1;
    started = 1'b1;
  endtask

  task automatic runProgram();
    int limit;
    // generous bound, ten cycles per word plus slack
    limit = 10 * progLen + 100;
    phase = "run";
    cycleCount = 0;
    while (!halted && cycleCount < limit)
    begin
      @(negedge clk);
      cycleCount++;
    end
    assert (halted)
    else
    begin
      errorCount++;
      $display("timeout, halted did not rise within %0d cycles", limit);
    end
    if (halted)
    begin
      // nothing may retire after HLT
      repeat (postHalt) @(negedge clk);
      checkCount++;
      assert (outCount == expCount)
      else
      begin
        errorCount++;
        $display("Fail output count: expected %0d, actual %0d", expCount, outCount);
      end
    end
  endtask

  initial
  begin
    rst = 1'b1;
    start = 1'b0;
    inputPort = '0;
    loadWe = 1'b0;
    loadAddr = '0;
    loadData = '0;
    started = 1'b0;
    errorCount = 0;
    checkCount = 0;
    outCount = 0;
    cycleCount = 0;
    phase = "reset";
    $readmemh("sim/programVectors.txt", vectors);
    progLen = vectors[1];
    expCount = vectors[2];
    inputPort = vectors[0];
    repeat (4) @(posedge clk);
    #driveDelay;
    rst = 1'b0;
    vectorsOk = (progLen > 0) && (hdrWords + progLen + expCount <= vecDepth);
    assert (vectorsOk)
    else
    begin
      errorCount++;
      $display("vector file header is missing or does not fit the buffer");
    end
    if (vectorsOk)
    begin
      loadProgram();
      releaseCore();
      runProgram();
    end
    $display("checks: %0d, errors: %0d, outputs: %0d of %0d, cycles: %0d",
      checkCount, errorCount, outCount, expCount, cycleCount);
    if (errorCount == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: sim/programVectors.txt
// one hex word per line: input port, program length, output count,
// then the program words from address 0, then the expected output words
A5C3    // input port value
001A    // 26 program words
0008    // 8 expected outputs
42C5    // 00 LDM r1, 0x0C5
443A    // 01 LDM r2, 0x03A
1650    // 02 ADD r3, r1, r2
80C0    // 03 OUT r3
2888    // 04 SUB r4, r2, r1  wraps below zero
8100    // 05 OUT r4
3B18    // 06 AND r5, r4, r3
8140    // 07 OUT r5
1D68    // 08 ADD r6, r5, r5
1DA8    // 09 ADD r6, r6, r5  depends on the line above
8180    // 0A OUT r6
6900    // 0B STD r4, 0x100
5F00    // 0C LDD r7, 0x100
81C0    // 0D OUT r7  load data forwarded
6DFF    // 0E STD r6, 0x1FF
53FF    // 0F LDD r1, 0x1FF
1478    // 10 ADD r2, r1, r7  reads the loaded r1
8080    // 11 OUT r2
4000    // 12 LDM r0, 0
9015    // 13 JZ r0, 0x15  taken
80C0    // 14 OUT r3  skipped
9A17    // 15 JZ r5, 0x17  not taken
8140    // 16 OUT r5
7600    // 17 IN r3
80C0    // 18 OUT r3
F000    // 19 HLT
00FF    // 0xC5 + 0x3A
FF75    // 0x3A - 0xC5
0075    // 0xFF75 & 0x00FF
015F    // 3 * 0x75
FF75    // stored and reloaded r4
00D4    // 0x015F + 0xFF75
0075    // fall-through OUT r5
A5C3    // input port

// File: build.f
common/cpuPkg.sv
common/wbBus.sv
fetch/fetchUnit.sv
execute/executeStage.sv
src/regFile.sv
src/memStage.sv
src/memArbiter.sv
src/unifiedMemory.sv
src/processor.sv
sim/processorTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module processorTb \
  -f build.f \
  -Mdir obj_dir -o simv \
  && simOut="$(./obj_dir/simv)" \
  && printf '%s\n' "$simOut" \
  && printf '%s\n' "$simOut" | grep -q "All checks passed" \
  || { echo "simulation did not pass"; exit 1; }

echo "simulation passed"
